/* flist.f */
rtl/scramble_pkg.sv
rtl/icache_ram_pkg.sv
rtl/scramble_key_ctrl.sv
rtl/scr_ram_bank.sv
rtl/ram_rsp_gather.sv
rtl/icache_ram_top.sv
tests/icache_ram_assertions.sv
tests/tb_icache_ram.sv

/* tests/tb_icache_ram.sv */
/*
 * Testbench for the instruction cache RAM top level, random tag and line
 * traffic against a scrambling model, key request handshake and watchdog
 */
`default_nettype none

module tb_icache_ram;

  localparam int unsigned NUM_WAYS     = icache_ram_pkg::IC_NUM_WAYS;
  localparam int unsigned NUM_LINES    = icache_ram_pkg::IC_NUM_LINES;
  localparam int unsigned IDX_W        = icache_ram_pkg::IC_INDEX_W;
  localparam int unsigned TAG_W        = icache_ram_pkg::IC_TAG_SIZE;
  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned RAND_OPS     = 200;
  localparam int unsigned MAX_DELAY    = 12;
  localparam logic [31:0] SEED         = 32'h6afc_c524;
  // Upper bound of cycles per test in test order
  localparam int unsigned TEST_CYCLES  = 3 + (NUM_LINES + RAND_OPS + 1) + (MAX_DELAY + 4)
                                         + (MAX_DELAY + 6) + (3 * NUM_LINES + 2);
  localparam longint unsigned WATCHDOG_TIME =
    longint'(RESET_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD;

  logic                         clk_i = 1'b0;
  logic                         rst_ni;
  scramble_pkg::scr_key_in_t    scr_key_i;
  logic                         icache_inval_i;
  logic                         scramble_req_o;
  icache_ram_pkg::ic_tag_req_t  tag_req_i;
  icache_ram_pkg::ic_data_req_t data_req_i;
  icache_ram_pkg::ic_rsp_t      rsp_o;

  // Next-cycle inputs set by the operation tasks
  icache_ram_pkg::ic_tag_req_t  nxt_tag_req;
  icache_ram_pkg::ic_data_req_t nxt_data_req;
  scramble_pkg::scr_key_in_t    nxt_key;
  logic                         nxt_inval;

  // Model of the scrambled rows and the key registers
  icache_ram_pkg::ic_tag_t  m_tag  [NUM_WAYS][NUM_LINES];
  icache_ram_pkg::ic_line_t m_line [NUM_WAYS][NUM_LINES];
  logic [31:0]              m_key;
  logic [31:0]              m_nonce;
  logic                     m_req;
  logic                     m_key_valid;

  logic [NUM_WAYS-1:0]      exp_rvalid;
  logic                     exp_rerror;
  icache_ram_pkg::ic_tag_t  exp_tag  [NUM_WAYS];
  icache_ram_pkg::ic_line_t exp_line [NUM_WAYS];

  int unsigned errors;
  int unsigned checks;
  int unsigned tests;
  int unsigned delay;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  icache_ram_top u_icache_ram_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .scr_key_i      (scr_key_i),
    .icache_inval_i (icache_inval_i),
    .scramble_req_o (scramble_req_o),
    .tag_req_i      (tag_req_i),
    .data_req_i     (data_req_i),
    .rsp_o          (rsp_o)
  );

  bind icache_ram_top icache_ram_assertions u_icache_ram_assertions (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .icache_inval_i (icache_inval_i),
    .scramble_req_i (scramble_req_o),
    .tag_req_i      (tag_req_i),
    .rsp_i          (rsp_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Model helpers and checks
  ////////////////////////////////////////////////////////////////////////////

  // Key and nonce mix doubled to 64 bits with the index over every nibble
  function automatic logic [63:0] key_stream(input logic [31:0] key, input logic [31:0] nonce,
                                             input icache_ram_pkg::ic_index_t idx);
    return {2{key ^ nonce}} ^ {16{idx}};
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic cycle();
    logic [NUM_WAYS-1:0]       rd;
    icache_ram_pkg::ic_index_t row;
    logic [63:0]               ks;
    @(posedge clk_i);
    tag_req_i      <= nxt_tag_req;
    data_req_i     <= nxt_data_req;
    scr_key_i      <= nxt_key;
    icache_inval_i <= nxt_inval;
    @(negedge clk_i);
    // Response here belongs to the request of the previous cycle
    check_value("scramble_req_o", 64'(scramble_req_o), 64'(m_req));
    check_value("rsp_o.rvalid", 64'(rsp_o.rvalid), 64'(exp_rvalid));
    check_value("rsp_o.rerror", 64'(rsp_o.rerror), 64'(exp_rerror));
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (exp_rvalid[w]) begin
        check_value($sformatf("rsp_o.tag_rdata[%0d]", w), 64'(rsp_o.tag_rdata[w]),
                    64'(exp_tag[w]));
        check_value($sformatf("rsp_o.line_rdata[%0d]", w), rsp_o.line_rdata[w], exp_line[w]);
      end
    end
    row        = nxt_tag_req.index ^ m_key[IDX_W-1:0];
    ks         = key_stream(m_key, m_nonce, nxt_tag_req.index);
    rd         = nxt_tag_req.req & {NUM_WAYS{~nxt_tag_req.write}};
    exp_rvalid = rd;
    exp_rerror = (|rd) & ~m_key_valid;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (rd[w]) begin
        exp_tag[w]  = m_tag[w][row] ^ ks[TAG_W-1:0];
        exp_line[w] = m_line[w][row] ^ ks;
      end else if (nxt_tag_req.write && nxt_tag_req.req[w]) begin
        m_tag[w][row]  = nxt_tag_req.wdata ^ ks[TAG_W-1:0];
        m_line[w][row] = nxt_data_req.wdata ^ ks;
      end
    end
    // Key loads on every valid strobe whether or not a request is pending
    if (m_req && nxt_key.valid) begin
      m_req       = 1'b0;
      m_key_valid = 1'b1;
    end else if (!m_req && nxt_inval) begin
      m_req       = 1'b1;
      m_key_valid = 1'b0;
    end
    if (nxt_key.valid) begin
      m_key   = nxt_key.key;
      m_nonce = nxt_key.nonce;
    end
    nxt_tag_req  = '0;
    nxt_data_req = '0;
    nxt_key      = '0;
    nxt_inval    = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_op(input logic [NUM_WAYS-1:0] ways, input icache_ram_pkg::ic_index_t idx,
                          input icache_ram_pkg::ic_tag_t tag,
                          input icache_ram_pkg::ic_line_t line);
    nxt_tag_req  = '{req: ways, write: 1'b1, index: idx, wdata: tag};
    nxt_data_req = '{req: ways, write: 1'b1, index: idx, wdata: line};
    cycle();
  endtask

  task automatic read_op(input logic [NUM_WAYS-1:0] ways, input icache_ram_pkg::ic_index_t idx);
    nxt_tag_req  = '{req: ways, write: 1'b0, index: idx, wdata: '0};
    nxt_data_req = '{req: ways, write: 1'b0, index: idx, wdata: '0};
    cycle();
  endtask

  task automatic key_load(input logic [31:0] key, input logic [31:0] nonce);
    nxt_key = '{valid: 1'b1, key: key, nonce: nonce};
    cycle();
  endtask

  task automatic report_test(input string name, input int unsigned errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d mismatches", tests, name, errors - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned start;
    void'($urandom(SEED));
    rst_ni         = 1'b0;
    scr_key_i      = '0;
    icache_inval_i = 1'b0;
    tag_req_i      = '0;
    data_req_i     = '0;
    nxt_tag_req    = '0;
    nxt_data_req   = '0;
    nxt_key        = '0;
    nxt_inval      = 1'b0;
    m_key          = scramble_pkg::SCRAMBLE_KEY_DEFAULT;
    m_nonce        = scramble_pkg::SCRAMBLE_NONCE_DEFAULT;
    m_req          = 1'b0;
    m_key_valid    = 1'b1;
    exp_rvalid     = '0;
    exp_rerror     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    start = errors;
    @(negedge clk_i);
    check_value("scramble_req_o", 64'(scramble_req_o), 64'd0);
    write_op('1, 4'd5, 22'h2a_5c31, 64'h0123_4567_89ab_cdef);
    read_op('1, 4'd5);
    cycle();
    report_test("default key write and read", start);

    start = errors;
    for (int i = 0; i < NUM_LINES; i++) begin
      write_op('1, IDX_W'(i), TAG_W'($urandom), {$urandom, $urandom});
    end
    for (int i = 0; i < RAND_OPS; i++) begin
      if ($urandom % 2) begin
        write_op(NUM_WAYS'($urandom_range(3, 1)), IDX_W'($urandom), TAG_W'($urandom),
                 {$urandom, $urandom});
      end else begin
        read_op(NUM_WAYS'($urandom_range(3, 1)), IDX_W'($urandom));
      end
    end
    cycle();
    report_test("random back-to-back traffic", start);

    start = errors;
    nxt_inval = 1'b1;
    cycle();
    delay = 4 + $urandom % (MAX_DELAY - 3);
    repeat (delay) cycle();
    key_load($urandom, $urandom);
    repeat (2) cycle();
    report_test("key request handshake", start);

    start = errors;
    nxt_inval = 1'b1;
    cycle();
    delay = 4 + $urandom % (MAX_DELAY - 3);
    repeat (delay) read_op(NUM_WAYS'($urandom_range(3, 1)), IDX_W'($urandom));
    key_load($urandom, $urandom);
    read_op('1, IDX_W'($urandom));
    cycle();
    report_test("read error while key invalid", start);

    start = errors;
    key_load($urandom, $urandom);
    for (int i = 0; i < NUM_LINES; i++) begin
      read_op('1, IDX_W'(i));
    end
    for (int i = 0; i < NUM_LINES; i++) begin
      write_op('1, IDX_W'(i), TAG_W'($urandom), {$urandom, $urandom});
    end
    for (int i = 0; i < NUM_LINES; i++) begin
      read_op('1, IDX_W'(i));
    end
    cycle();
    report_test("old and fresh entries after key change", start);

    errors += u_icache_ram_top.u_icache_ram_assertions.fail_count;
    $display("tests %0d, checks %0d, assertion failures %0d, errors %0d", tests, checks,
             u_icache_ram_top.u_icache_ram_assertions.fail_count, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: the tests did not complete within %0d time units", WATCHDOG_TIME);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/icache_ram_assertions.sv */
/*
 * Concurrent checks on the key request handshake
 * and on read response timing
 */
`default_nettype none

module icache_ram_assertions (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        icache_inval_i,
  input  logic                        scramble_req_i,
  input  icache_ram_pkg::ic_tag_req_t tag_req_i,
  input  icache_ram_pkg::ic_rsp_t     rsp_i
);

  localparam int unsigned NUM_WAYS = icache_ram_pkg::IC_NUM_WAYS;

  logic [NUM_WAYS-1:0] rd_req;

  // Count of failed checks
  int unsigned fail_count = 0;

  assign rd_req = tag_req_i.req & {NUM_WAYS{~tag_req_i.write}};

  ////////////////////////////////////////////////////////////////////////////
  // Key handshake
  ////////////////////////////////////////////////////////////////////////////

  req_rises_on_inval: assert property (@(posedge clk_i) disable iff (!rst_ni)
    icache_inval_i && !scramble_req_i |=> scramble_req_i)
    else begin
      fail_count++;
      $error("key request did not rise after an invalidation");
    end

  // No request without an invalidation before it
  req_needs_inval: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !icache_inval_i && !scramble_req_i |=> !scramble_req_i)
    else begin
      fail_count++;
      $error("key request rose without an invalidation");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Read responses
  ////////////////////////////////////////////////////////////////////////////

  rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    1'b1 |=> rsp_i.rvalid == $past(rd_req))
    else begin
      fail_count++;
      $error("read-valid does not follow its request by one cycle");
    end

  rerror_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.rerror |-> |rsp_i.rvalid)
    else begin
      fail_count++;
      $error("read error flagged without a read-valid bit");
    end

endmodule

`default_nettype wire

/* rtl/icache_ram_top.sv */
/*
 * Instruction cache RAM top level, key controller,
 * scrambled tag and data banks per way and the response gatherer
 */
`default_nettype none

module icache_ram_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Key provider
  input  scramble_pkg::scr_key_in_t    scr_key_i,
  input  logic                         icache_inval_i,
  output logic                         scramble_req_o,

  // Cache side
  input  icache_ram_pkg::ic_tag_req_t  tag_req_i,
  input  icache_ram_pkg::ic_data_req_t data_req_i,
  output icache_ram_pkg::ic_rsp_t      rsp_o
);

  localparam int unsigned NUM_WAYS = icache_ram_pkg::IC_NUM_WAYS;

  scramble_pkg::scr_key_t                    scr_key;
  logic                                      key_valid;
  icache_ram_pkg::ic_tag_t [NUM_WAYS-1:0]    tag_rdata;
  icache_ram_pkg::ic_line_t [NUM_WAYS-1:0]   line_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Key control
  ////////////////////////////////////////////////////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i,
    .rst_ni,
    .scr_key_i,
    .icache_inval_i,
    .scramble_req_o,
    .key_valid_o    (key_valid),
    .key_o          (scr_key)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Banks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar way = 0; way < NUM_WAYS; way++) begin : gen_ways

    scr_ram_bank #(
      .payload_t (icache_ram_pkg::ic_tag_t)
    ) u_tag_bank (
      .clk_i,
      .rst_ni,
      .key_i     (scr_key),
      .req_i     (tag_req_i.req[way]),
      .write_i   (tag_req_i.write),
      .index_i   (tag_req_i.index),
      .wdata_i   (tag_req_i.wdata),
      .rdata_o   (tag_rdata[way])
    );

    scr_ram_bank #(
      .payload_t (icache_ram_pkg::ic_line_t)
    ) u_data_bank (
      .clk_i,
      .rst_ni,
      .key_i     (scr_key),
      .req_i     (data_req_i.req[way]),
      .write_i   (data_req_i.write),
      .index_i   (data_req_i.index),
      .wdata_i   (data_req_i.wdata),
      .rdata_o   (line_rdata[way])
    );

  end

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  ram_rsp_gather u_ram_rsp_gather (
    .clk_i,
    .rst_ni,
    .tag_req_i,
    .key_valid_i  (key_valid),
    .tag_rdata_i  (tag_rdata),
    .line_rdata_i (line_rdata),
    .rsp_o
  );

endmodule

`default_nettype wire

/* rtl/ram_rsp_gather.sv */
/*
 * Read response gatherer, per-way read-valid and read-error flags
 * packed with the read data of every way
 */
`default_nettype none

module ram_rsp_gather (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  icache_ram_pkg::ic_tag_req_t tag_req_i,
  input  logic                        key_valid_i,

  input  icache_ram_pkg::ic_tag_t [icache_ram_pkg::IC_NUM_WAYS-1:0]  tag_rdata_i,
  input  icache_ram_pkg::ic_line_t [icache_ram_pkg::IC_NUM_WAYS-1:0] line_rdata_i,

  output icache_ram_pkg::ic_rsp_t     rsp_o
);

  localparam int unsigned NUM_WAYS = icache_ram_pkg::IC_NUM_WAYS;

  logic [NUM_WAYS-1:0] rd_req;
  logic [NUM_WAYS-1:0] rvalid_q;
  logic                rerror_q;

  ////////////////////////////////////////////////////////////////////////////
  // Completion flags
  ////////////////////////////////////////////////////////////////////////////

  // Tag and data requests go out together, tag side stands for both
  assign rd_req = tag_req_i.req & {NUM_WAYS{~tag_req_i.write}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
      rerror_q <= 1'b0;
    end else begin
      rvalid_q <= rd_req;
      // Sampled at request time
      rerror_q <= (|rd_req) & ~key_valid_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  // Bank data is already registered
  always_comb begin
    rsp_o            = '0;
    rsp_o.rvalid     = rvalid_q;
    rsp_o.rerror     = rerror_q;
    rsp_o.tag_rdata  = tag_rdata_i;
    rsp_o.line_rdata = line_rdata_i;
  end

endmodule

`default_nettype wire

/* rtl/scr_ram_bank.sv */
/*
 * Single-port scrambled RAM bank, index and content scrambled with
 * a keystream built from key, nonce and line index
 */
`default_nettype none

module scr_ram_bank #(
  parameter type payload_t = icache_ram_pkg::ic_tag_t
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  scramble_pkg::scr_key_t   key_i,

  input  logic                     req_i,
  input  logic                     write_i,
  input  icache_ram_pkg::ic_index_t index_i,
  input  payload_t                 wdata_i,

  output payload_t                 rdata_o
);

  localparam int unsigned PAYLOAD_W = $bits(payload_t);
  localparam int unsigned KEY_W     = scramble_pkg::SCRAMBLE_KEY_W;
  localparam int unsigned IDX_W     = icache_ram_pkg::IC_INDEX_W;
  localparam int unsigned DEPTH     = icache_ram_pkg::IC_NUM_LINES;

  logic [PAYLOAD_W-1:0] mem [DEPTH];
  logic [PAYLOAD_W-1:0] rdata_q;
  logic [PAYLOAD_W-1:0] keystream;
  logic [KEY_W-1:0]     key_mix;
  logic [IDX_W-1:0]     row;

  ////////////////////////////////////////////////////////////////////////////
  // Address and keystream
  ////////////////////////////////////////////////////////////////////////////

  assign row     = index_i ^ key_i.key[IDX_W-1:0];
  assign key_mix = key_i.key ^ key_i.nonce;

  // Key mix repeated over the payload, then the logical index on top
  always_comb begin
    for (int unsigned i = 0; i < PAYLOAD_W; i++) begin
      keystream[i] = key_mix[i % KEY_W] ^ index_i[i % IDX_W];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i && write_i) begin
      mem[row] <= wdata_i ^ keystream;
    end
  end

  // Descrambled with whatever key is current at the read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !write_i) begin
      rdata_q <= mem[row] ^ keystream;
    end
  end

  assign rdata_o = payload_t'(rdata_q);

endmodule

`default_nettype wire

/* rtl/scramble_key_ctrl.sv */
/*
 * Scrambling key controller, key and nonce registers
 * with the new-key request and key-valid handshake
 */
`default_nettype none

module scramble_key_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  scramble_pkg::scr_key_in_t scr_key_i,
  input  logic                   icache_inval_i,

  output logic                   scramble_req_o,
  output logic                   key_valid_o,
  output scramble_pkg::scr_key_t key_o
);

  scramble_pkg::scr_key_t key_q;
  logic                   req_d, req_q;
  logic                   key_valid_d, key_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Key and nonce
  ////////////////////////////////////////////////////////////////////////////

  // Any valid strobe loads, pending request or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q.key   <= scramble_pkg::SCRAMBLE_KEY_DEFAULT;
      key_q.nonce <= scramble_pkg::SCRAMBLE_NONCE_DEFAULT;
    end else if (scr_key_i.valid) begin
      key_q.key   <= scr_key_i.key;
      key_q.nonce <= scr_key_i.nonce;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and valid handshake
  ////////////////////////////////////////////////////////////////////////////

  // Request rises on invalidation, holds until a valid key shows up
  assign req_d = req_q ? ~scr_key_i.valid : icache_inval_i;

  // Key goes stale on invalidation
  assign key_valid_d = req_q          ? scr_key_i.valid :
                       icache_inval_i ? 1'b0            :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = key_valid_q;
  assign key_o          = key_q;

endmodule

`default_nettype wire

/* rtl/icache_ram_pkg.sv */
/*
 * Instruction cache RAM geometry, tag and line payload types,
 * and the request and response structs of the RAM side
 */
`default_nettype none

package icache_ram_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned IC_NUM_WAYS  = 2;
  localparam int unsigned IC_NUM_LINES = 16;
  localparam int unsigned IC_INDEX_W   = $clog2(IC_NUM_LINES);
  localparam int unsigned IC_TAG_SIZE  = 22;
  localparam int unsigned IC_LINE_SIZE = 64;

  typedef logic [IC_TAG_SIZE-1:0]  ic_tag_t;
  typedef logic [IC_LINE_SIZE-1:0] ic_line_t;
  typedef logic [IC_INDEX_W-1:0]   ic_index_t;

  ////////////////////////////////////////////////////////////////////////////
  // Requests and response
  ////////////////////////////////////////////////////////////////////////////

  // One request bit per way, the rest is shared by all ways
  typedef struct packed {
    logic [IC_NUM_WAYS-1:0] req;
    logic                   write;
    ic_index_t              index;
    ic_tag_t                wdata;
  } ic_tag_req_t;

  typedef struct packed {
    logic [IC_NUM_WAYS-1:0] req;
    logic                   write;
    ic_index_t              index;
    ic_line_t               wdata;
  } ic_data_req_t;

  // Read completion, data of every way is returned together
  typedef struct packed {
    logic [IC_NUM_WAYS-1:0]   rvalid;
    logic                     rerror;
    ic_tag_t [IC_NUM_WAYS-1:0]  tag_rdata;
    ic_line_t [IC_NUM_WAYS-1:0] line_rdata;
  } ic_rsp_t;

endpackage

`default_nettype wire

/* rtl/scramble_pkg.sv */
/*
 * Scrambling key and nonce widths with their reset values,
 * plus the key bundles passed from the key provider to the RAM banks
 */
`default_nettype none

package scramble_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and reset values
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned SCRAMBLE_KEY_W   = 32;
  localparam int unsigned SCRAMBLE_NONCE_W = 32;

  localparam logic [SCRAMBLE_KEY_W-1:0]   SCRAMBLE_KEY_DEFAULT   = 32'h3b9f_04c2;
  localparam logic [SCRAMBLE_NONCE_W-1:0] SCRAMBLE_NONCE_DEFAULT = 32'h9d1e_67a5;

  ////////////////////////////////////////////////////////////////////////////
  // Key bundles
  ////////////////////////////////////////////////////////////////////////////

  // From the key provider, valid acts as a load strobe
  typedef struct packed {
    logic                        valid;
    logic [SCRAMBLE_KEY_W-1:0]   key;
    logic [SCRAMBLE_NONCE_W-1:0] nonce;
  } scr_key_in_t;

  // Registered copy shared by all banks
  typedef struct packed {
    logic [SCRAMBLE_KEY_W-1:0]   key;
    logic [SCRAMBLE_NONCE_W-1:0] nonce;
  } scr_key_t;

endpackage

`default_nettype wire
